/* Bender.yml */
package:
  name: tag_store

sources:
  - logic/tag_store_pkg.sv
  - logic/tag_ram_if.sv
  - logic/tag_ram_bank.sv
  - logic/tag_array.sv
  - logic/victim_select.sv
  - logic/tag_store_ctrl.sv
  - logic/tag_store_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tag_store_tb.sv

/* all.f */
+incdir+tests
logic/tag_store_pkg.sv
logic/tag_ram_if.sv
logic/tag_ram_bank.sv
logic/tag_array.sv
logic/victim_select.sv
logic/tag_store_ctrl.sv
logic/tag_store_top.sv
tests/tag_store_tb.sv

/* logic/tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

module tag_array (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  tag_ram_if.array                                             ram,
  input  tag_store_pkg::tag_t                                   cmp_tag_i,
  input  tag_store_pkg::way_t                                   cmp_mask_i,
  output logic                                                 rvalid_o,
  output tag_store_pkg::way_t                                   hit_o,
  output tag_store_pkg::way_t                                   valid_o,
  output tag_store_pkg::way_t                                   dirty_o,
  output tag_store_pkg::tag_entry_t [tag_store_pkg::NumWays-1:0] entries_o
);
  import tag_store_pkg::*;

  // Read token of every way
  way_t way_rvalid;

  // One bank per way, all share address and write data
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    logic tag_equal;

    tag_ram_bank i_tag_ram_bank (
      .clk_i    ( clk_i          ),
      .arst_n_i ( arst_n_i       ),
      .req_i    ( ram.req[w]     ),
      .we_i     ( ram.we[w]      ),
      .index_i  ( ram.index      ),
      .wdata_i  ( ram.wdata      ),
      .rdata_o  ( entries_o[w]   ),
      .rvalid_o ( way_rvalid[w]  )
    );

    // Tag compare of this way
    assign tag_equal = (entries_o[w].tag == cmp_tag_i);

    // Status bits straight from the stored entry
    assign valid_o[w] = entries_o[w].valid;
    assign dirty_o[w] = entries_o[w].dirty;

    // Locked ways never hit, neither do empty lines
    assign hit_o[w] = cmp_mask_i[w] & entries_o[w].valid & tag_equal;
  end

  // Only requested ways return a token, any of them marks the data valid
  assign rvalid_o = |way_rvalid;

endmodule

`default_nettype wire

/* logic/tag_ram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module tag_ram_bank (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  tag_store_pkg::index_t     index_i,
  input  tag_store_pkg::tag_entry_t wdata_i,
  output tag_store_pkg::tag_entry_t rdata_o,
  output logic                     rvalid_o
);
  import tag_store_pkg::*;

  // Storage of one way, one entry per set
  tag_entry_t mem_q [NumSets];

  // Read token and read data pipelines
  logic [TagLatency-1:0] rvalid_q;
  tag_entry_t            rdata_q [TagLatency];

  logic rd_en;

  // A read is an access without write enable
  assign rd_en = req_i & ~we_i;

  // Memory and read token, all cleared so that the cache starts empty
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned s = 0; s < NumSets; s++) begin
        mem_q[s] <= '0;
      end
      rvalid_q <= '0;
    end else begin
      if (req_i && we_i) begin
        mem_q[index_i] <= wdata_i;
      end
      rvalid_q[0] <= rd_en;
      for (int unsigned l = 1; l < TagLatency; l++) begin
        rvalid_q[l] <= rvalid_q[l-1];
      end
    end
  end

  // Read data, first stage only loads on a read so the output holds afterwards
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q[0] <= mem_q[index_i];
    end
    for (int unsigned l = 1; l < TagLatency; l++) begin
      rdata_q[l] <= rdata_q[l-1];
    end
  end

  assign rdata_o  = rdata_q[TagLatency-1];
  assign rvalid_o = rvalid_q[TagLatency-1];

endmodule

`default_nettype wire

/* logic/tag_ram_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface tag_ram_if;
  import tag_store_pkg::*;

  // Per-way access enable
  way_t       req;
  // Per-way write enable, only taken together with req
  way_t       we;
  // Shared set address for all ways
  index_t     index;
  // Shared write data for all ways
  tag_entry_t wdata;

  // Controller side drives the access
  modport ctrl (
    output req, we, index, wdata
  );

  // Array side receives it
  modport array (
    input req, we, index, wdata
  );

endinterface

`default_nettype wire

/* logic/tag_store_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tag_store_ctrl (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  tag_store_pkg::way_t                                   spm_lock_i,
  input  tag_store_pkg::op_e                                    req_op_i,
  input  tag_store_pkg::index_t                                 req_index_i,
  input  tag_store_pkg::tag_t                                   req_tag_i,
  input  logic                                                 req_dirty_i,
  input  tag_store_pkg::way_t                                   req_way_i,
  input  logic                                                 req_valid_i,
  output logic                                                 req_ready_o,
  output tag_store_pkg::way_t                                   res_way_o,
  output logic                                                 res_hit_o,
  output logic                                                 res_evict_o,
  output tag_store_pkg::tag_t                                   res_evict_tag_o,
  output logic                                                 res_valid_o,
  input  logic                                                 res_ready_i,
  tag_ram_if.ctrl                                              ram,
  input  logic                                                 rvalid_i,
  input  tag_store_pkg::way_t                                   hit_i,
  input  tag_store_pkg::way_t                                   valid_i,
  input  tag_store_pkg::way_t                                   dirty_i,
  input  tag_store_pkg::tag_entry_t [tag_store_pkg::NumWays-1:0] entries_i,
  output logic                                                 choose_o,
  output tag_store_pkg::way_t                                   unlocked_o,
  input  tag_store_pkg::way_t                                   victim_way_i,
  input  tag_store_pkg::way_idx_t                               victim_idx_i,
  input  logic                                                 victim_evict_i
);
  import tag_store_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Wait,
    Respond
  } state_e;

  state_e state_q, state_d;

  // Registered request
  op_e    op_q;
  index_t index_q;
  tag_t   tag_q;
  logic   req_dirty_q;
  way_t   way_q;
  way_t   unlocked_q;
  logic   load_req;

  // Read data held while the response waits
  way_t                      hit_q, valid_q, dirty_q;
  tag_entry_t [NumWays-1:0]  entries_q;
  way_t                      hit_sel, valid_sel, dirty_sel;
  tag_entry_t [NumWays-1:0]  entries_sel;
  logic                      latch_rd;

  logic     resp_active;
  logic     upgrade;
  way_idx_t flush_idx;

  // Response is up once data arrived, and stays up in Respond
  assign resp_active = ((state_q == Wait) && rvalid_i) || (state_q == Respond);
  assign res_valid_o = resp_active;

  // Capture the read data in the cycle it arrives
  assign latch_rd = (state_q == Wait) && rvalid_i;

  // Live data in the arrival cycle and the held copy after that
  assign hit_sel     = (state_q == Respond) ? hit_q     : hit_i;
  assign valid_sel   = (state_q == Respond) ? valid_q   : valid_i;
  assign dirty_sel   = (state_q == Respond) ? dirty_q   : dirty_i;
  assign entries_sel = (state_q == Respond) ? entries_q : entries_i;

  // Clean hit with a dirty request marks the line dirty
  assign upgrade = req_dirty_q & ~(|(hit_sel & dirty_sel));

  // Ways the lookup may touch are frozen with the request
  assign unlocked_o = unlocked_q;

  // Binary number of the flushed way
  always_comb begin
    flush_idx = '0;
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (way_q[w]) begin
        flush_idx = way_idx_t'(w);
      end
    end
  end

  // Flush writes back a cleared entry
  // Refill and dirty upgrade both store the request tag with the request's dirty bit
  // Its tag also feeds the tag compare of the array
  always_comb begin : proc_wdata
    if (op_q == OpFlush) begin
      ram.wdata = '0;
    end else begin
      ram.wdata = tag_entry_t'{valid: 1'b1, dirty: req_dirty_q, tag: tag_q};
    end
  end

  // Sequencing, memory access and write-back
  always_comb begin : proc_ctrl
    state_d     = state_q;
    req_ready_o = 1'b0;
    load_req    = 1'b0;
    choose_o    = 1'b0;
    ram.req     = '0;
    ram.we      = '0;
    ram.index   = index_q;
    unique case (state_q)
      Idle: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          load_req  = 1'b1;
          // Flush reads only its way, lookup reads every unlocked way
          ram.req   = (req_op_i == OpFlush) ? req_way_i : ~spm_lock_i;
          ram.index = req_index_i;
          state_d   = Wait;
        end
      end
      Wait, Respond: begin
        if (latch_rd && !res_ready_i) begin
          state_d = Respond;
        end
        if (resp_active && res_ready_i) begin
          state_d = Idle;
          if (op_q == OpFlush) begin
            // Clear the flushed entry
            ram.req = way_q;
            ram.we  = way_q;
          end else if (|hit_sel) begin
            if (upgrade) begin
              ram.req = hit_sel;
              ram.we  = hit_sel;
            end else if (req_valid_i && (req_op_i == OpLookup)) begin
              // Nothing to write so the next lookup can overlap
              req_ready_o = 1'b1;
              load_req    = 1'b1;
              ram.req     = ~spm_lock_i;
              ram.index   = req_index_i;
              state_d     = Wait;
            end
          end else begin
            // Miss refills the victim and advances its pointer
            choose_o = 1'b1;
            ram.req  = victim_way_i;
            ram.we   = victim_way_i;
          end
        end
      end
      default: state_d = Idle;
    endcase
  end

  // Response fields from the operation in flight
  always_comb begin : proc_response
    res_way_o       = '0;
    res_hit_o       = 1'b0;
    res_evict_o     = 1'b0;
    res_evict_tag_o = '0;
    if (op_q == OpFlush) begin
      res_way_o       = way_q;
      res_evict_o     = |(way_q & valid_sel & dirty_sel);
      res_evict_tag_o = entries_sel[flush_idx].tag;
    end else if (|hit_sel) begin
      res_way_o = hit_sel;
      res_hit_o = 1'b1;
    end else begin
      res_way_o       = victim_way_i;
      res_evict_o     = victim_evict_i;
      res_evict_tag_o = entries_sel[victim_idx_i].tag;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= Idle;
      op_q        <= OpLookup;
      index_q     <= '0;
      tag_q       <= '0;
      req_dirty_q <= 1'b0;
      way_q       <= '0;
      unlocked_q  <= '0;
    end else begin
      state_q <= state_d;
      if (load_req) begin
        op_q        <= req_op_i;
        index_q     <= req_index_i;
        tag_q       <= req_tag_i;
        req_dirty_q <= req_dirty_i;
        way_q       <= req_way_i;
        unlocked_q  <= ~spm_lock_i;
      end
    end
  end

  // Held read data
  always_ff @(posedge clk_i) begin
    if (latch_rd) begin
      hit_q     <= hit_i;
      valid_q   <= valid_i;
      dirty_q   <= dirty_i;
      entries_q <= entries_i;
    end
  end

endmodule

`default_nettype wire

/* logic/tag_store_pkg.sv */
`default_nettype none

package tag_store_pkg;

  // Cache geometry
  localparam int unsigned NumWays    = 32'd4;
  localparam int unsigned NumSets    = 32'd64;
  localparam int unsigned IndexWidth = 32'd6;
  localparam int unsigned TagWidth   = 32'd10;

  // Cycles from a read request until its data shows up
  localparam int unsigned TagLatency = 32'd1;

  // Width of a binary way number
  localparam int unsigned WayIdxWidth = $clog2(NumWays);

  // One-hot way or mask over all ways
  typedef logic [NumWays-1:0] way_t;

  // Binary way number
  typedef logic [WayIdxWidth-1:0] way_idx_t;

  // Set index, also the address into every way
  typedef logic [IndexWidth-1:0] index_t;

  // Tag part of the address
  typedef logic [TagWidth-1:0] tag_t;

  // One stored line descriptor
  typedef struct packed {
    // Line holds data
    logic valid;
    // Line was written since the fill
    logic dirty;
    // Stored tag
    tag_t tag;
  } tag_entry_t;

  // Operations of the request port
  typedef enum logic {
    // Compare the tag in all unlocked ways
    OpLookup = 1'b0,
    // Read out one way and clear it
    OpFlush  = 1'b1
  } op_e;

endpackage

`default_nettype wire

/* logic/tag_store_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tag_store_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tag_store_pkg::way_t   spm_lock_i,
  input  tag_store_pkg::op_e    req_op_i,
  input  tag_store_pkg::index_t req_index_i,
  input  tag_store_pkg::tag_t   req_tag_i,
  input  logic                  req_dirty_i,
  input  tag_store_pkg::way_t   req_way_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output tag_store_pkg::way_t   res_way_o,
  output logic                  res_hit_o,
  output logic                  res_evict_o,
  output tag_store_pkg::tag_t   res_evict_tag_o,
  output logic                  res_valid_o,
  input  logic                  res_ready_i
);
  import tag_store_pkg::*;

  // Array results
  logic                     rvalid;
  way_t                     hit, valid, dirty;
  tag_entry_t [NumWays-1:0] entries;

  // Victim choice
  logic     choose;
  way_t     unlocked;
  way_t     victim_way;
  way_idx_t victim_idx;
  logic     victim_evict;

  tag_ram_if ram_if ();

  tag_store_ctrl i_tag_store_ctrl (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .spm_lock_i      ( spm_lock_i      ),
    .req_op_i        ( req_op_i        ),
    .req_index_i     ( req_index_i     ),
    .req_tag_i       ( req_tag_i       ),
    .req_dirty_i     ( req_dirty_i     ),
    .req_way_i       ( req_way_i       ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .res_way_o       ( res_way_o       ),
    .res_hit_o       ( res_hit_o       ),
    .res_evict_o     ( res_evict_o     ),
    .res_evict_tag_o ( res_evict_tag_o ),
    .res_valid_o     ( res_valid_o     ),
    .res_ready_i     ( res_ready_i     ),
    .ram             ( ram_if          ),
    .rvalid_i        ( rvalid          ),
    .hit_i           ( hit             ),
    .valid_i         ( valid           ),
    .dirty_i         ( dirty           ),
    .entries_i       ( entries         ),
    .choose_o        ( choose          ),
    .unlocked_o      ( unlocked        ),
    .victim_way_i    ( victim_way      ),
    .victim_idx_i    ( victim_idx      ),
    .victim_evict_i  ( victim_evict    )
  );

  // Compare tag is the registered request tag carried on the write data
  tag_array i_tag_array (
    .clk_i      ( clk_i             ),
    .arst_n_i   ( arst_n_i          ),
    .ram        ( ram_if            ),
    .cmp_tag_i  ( ram_if.wdata.tag  ),
    .cmp_mask_i ( unlocked          ),
    .rvalid_o   ( rvalid            ),
    .hit_o      ( hit               ),
    .valid_o    ( valid             ),
    .dirty_o    ( dirty             ),
    .entries_o  ( entries           )
  );

  victim_select i_victim_select (
    .clk_i      ( clk_i        ),
    .arst_n_i   ( arst_n_i     ),
    .choose_i   ( choose       ),
    .unlocked_i ( unlocked     ),
    .valid_i    ( valid        ),
    .dirty_i    ( dirty        ),
    .way_o      ( victim_way   ),
    .idx_o      ( victim_idx   ),
    .evict_o    ( victim_evict )
  );

endmodule

`default_nettype wire

/* logic/victim_select.sv */
`timescale 1ns/10ps
`default_nettype none

module victim_select (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    choose_i,
  input  tag_store_pkg::way_t     unlocked_i,
  input  tag_store_pkg::way_t     valid_i,
  input  tag_store_pkg::way_t     dirty_i,
  output tag_store_pkg::way_t     way_o,
  output tag_store_pkg::way_idx_t idx_o,
  output logic                    evict_o
);
  import tag_store_pkg::*;

  // Round-robin pointer for full sets
  way_idx_t ptr_q;
  way_idx_t pick;
  way_t     free;

  // Unlocked ways that hold nothing yet
  assign free = unlocked_i & ~valid_i;

  always_comb begin : proc_choose
    logic        found;
    int unsigned cand;
    found = 1'b0;
    cand  = 0;
    pick  = '0;
    if (|free) begin
      // Lowest free way wins, scan downward so the last hit is the lowest
      for (int i = int'(NumWays) - 1; i >= 0; i--) begin
        if (free[i]) begin
          pick = way_idx_t'(i);
        end
      end
    end else begin
      // Set full, start at the pointer and skip locked ways upward
      for (int unsigned k = 0; k < NumWays; k++) begin
        cand = (ptr_q + k) % NumWays;
        if (!found && unlocked_i[cand]) begin
          found = 1'b1;
          pick  = way_idx_t'(cand);
        end
      end
    end
  end

  // Pointer only moves when it actually made the choice
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (choose_i && !(|free)) begin
      ptr_q <= (pick == way_idx_t'(NumWays - 1)) ? '0 : pick + 1'b1;
    end
  end

  assign idx_o   = pick;
  assign way_o   = way_t'(1) << pick;
  // Dirty victim has to be written back before the refill
  assign evict_o = dirty_i[pick];

endmodule

`default_nettype wire

/* tests/tag_store_model.svh */
`ifndef TAG_STORE_MODEL_SVH
`define TAG_STORE_MODEL_SVH

// Expected entry of every way and set
tag_entry_t model_mem [NumWays][NumSets];

// Expected round-robin pointer, one for the whole cache
int unsigned model_ptr;

// Cache is empty after reset
function automatic void reset_model();
  for (int unsigned w = 0; w < NumWays; w++) begin
    for (int unsigned s = 0; s < NumSets; s++) begin
      model_mem[w][s] = '0;
    end
  end
  model_ptr = 0;
endfunction

// Expected response of one request, the write-back is applied right away
function automatic expect_t predict_request(input op_e op, input index_t index,
                                            input tag_t new_tag, input logic new_dirty,
                                            input way_t flush_way, input way_t lock);
  expect_t     res;
  way_t        hits;
  way_t        free;
  logic        any_dirty;
  logic        found;
  int unsigned vic;
  int unsigned cand;
  res       = '0;
  hits      = '0;
  free      = '0;
  any_dirty = 1'b0;
  found     = 1'b0;
  vic       = 0;
  // Flush reports the old entry of one way and clears it
  if (op == OpFlush) begin
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (flush_way[w]) begin
        vic = w;
      end
    end
    res.way   = flush_way;
    res.evict = model_mem[vic][index].valid & model_mem[vic][index].dirty;
    res.tag   = model_mem[vic][index].tag;
    model_mem[vic][index] = '0;
    return res;
  end
  // Locked ways take no part in the lookup at all
  for (int unsigned w = 0; w < NumWays; w++) begin
    if (!lock[w]) begin
      if (!model_mem[w][index].valid) begin
        free[w] = 1'b1;
      end else if (model_mem[w][index].tag == new_tag) begin
        hits[w]   = 1'b1;
        any_dirty = any_dirty | model_mem[w][index].dirty;
      end
    end
  end
  if (hits != '0) begin
    res.way = hits;
    res.hit = 1'b1;
    // Clean hit turns dirty
    if (new_dirty && !any_dirty) begin
      for (int unsigned w = 0; w < NumWays; w++) begin
        if (hits[w]) begin
          model_mem[w][index].dirty = 1'b1;
        end
      end
    end
    return res;
  end
  if (free != '0) begin
    // Lowest empty way is filled first
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (!found && free[w]) begin
        vic   = w;
        found = 1'b1;
      end
    end
  end else begin
    // Full set, walk up from the pointer to the first unlocked way
    for (int unsigned k = 0; k < NumWays; k++) begin
      cand = (model_ptr + k) % NumWays;
      if (!found && !lock[cand]) begin
        vic   = cand;
        found = 1'b1;
      end
    end
    model_ptr = (vic + 1) % NumWays;
  end
  res.way   = way_t'(1) << vic;
  res.evict = model_mem[vic][index].dirty;
  res.tag   = model_mem[vic][index].tag;
  model_mem[vic][index] = tag_entry_t'{valid: 1'b1, dirty: new_dirty, tag: new_tag};
  return res;
endfunction

`endif

/* tests/tag_store_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tag_store_tb;
  import tag_store_pkg::*;

  localparam logic [31:0] Seed         = 32'he2daacdd;
  localparam time         ClkPeriod    = 40ns;
  localparam time         DriveDelay   = 2ns;
  localparam int unsigned NumRandom    = 400;
  localparam int unsigned ReqTimeout   = 200;
  localparam int unsigned RspTimeout   = 200;
  localparam int unsigned DrainTimeout = 500;

  // One expected response
  typedef struct packed {
    way_t way;
    logic hit;
    logic evict;
    tag_t tag;
  } expect_t;

  logic   clk_i;
  logic   arst_n_i;
  way_t   spm_lock_i;
  op_e    req_op_i;
  index_t req_index_i;
  tag_t   req_tag_i;
  logic   req_dirty_i;
  way_t   req_way_i;
  logic   req_valid_i;
  logic   req_ready_o;
  way_t   res_way_o;
  logic   res_hit_o;
  logic   res_evict_o;
  tag_t   res_evict_tag_o;
  logic   res_valid_o;
  logic   res_ready_i;

  // Responses still owed by the DUT, oldest first
  expect_t     exp_q [$];
  int unsigned num_sent;
  int unsigned num_checked;
  // Random back-pressure on the response port
  logic        stall_enable;
  // Separate generator states for the request and response sides
  logic [31:0] drv_state;
  logic [31:0] rsp_state;

  `include "tag_store_model.svh"

  tag_store_top tag_store_top_i (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .spm_lock_i      ( spm_lock_i      ),
    .req_op_i        ( req_op_i        ),
    .req_index_i     ( req_index_i     ),
    .req_tag_i       ( req_tag_i       ),
    .req_dirty_i     ( req_dirty_i     ),
    .req_way_i       ( req_way_i       ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .res_way_o       ( res_way_o       ),
    .res_hit_o       ( res_hit_o       ),
    .res_evict_o     ( res_evict_o     ),
    .res_evict_tag_o ( res_evict_tag_o ),
    .res_valid_o     ( res_valid_o     ),
    .res_ready_i     ( res_ready_i     )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // LCG step
  function automatic logic [31:0] next_random(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: time %0t, %s = %0h, expected %0h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  // Let cycles pass with the request port idle
  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      #DriveDelay;
    end
  endtask

  // Offer one request until the DUT takes it, entered and left just after an edge
  task automatic send_request(input op_e op, input index_t index, input tag_t tag,
                              input logic dirty, input way_t way, input way_t lock);
    int unsigned waited;
    logic        taken;
    waited      = 0;
    taken       = 1'b0;
    req_op_i    = op;
    req_index_i = index;
    req_tag_i   = tag;
    req_dirty_i = dirty;
    req_way_i   = way;
    spm_lock_i  = lock;
    req_valid_i = 1'b1;
    while (!taken) begin
      // Handshake is settled mid-cycle, it holds until the edge
      @(negedge clk_i);
      if (req_ready_o) begin
        taken = 1'b1;
        exp_q.push_back(predict_request(op, index, tag, dirty, way, lock));
        num_sent++;
      end else begin
        waited++;
        if (waited > ReqTimeout) begin
          $display("request at index %0d was not accepted in time", index);
          stop_on_failure();
        end
      end
      @(posedge clk_i);
      #DriveDelay;
    end
    req_valid_i = 1'b0;
  endtask

  // Drives res_ready_i and checks every response against the model
  task automatic watch_responses();
    logic [31:0] r;
    logic        pending;
    logic        accepted;
    expect_t     held;
    expect_t     exp;
    int unsigned stall;
    pending = 1'b0;
    stall   = 0;
    forever begin
      @(posedge clk_i);
      #DriveDelay;
      r = next_random(rsp_state);
      res_ready_i = stall_enable ? (r[31:30] != 2'b00) : 1'b1;
      @(negedge clk_i);
      accepted = 1'b0;
      if (res_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("a response arrived with no request outstanding");
          stop_on_failure();
        end
        // A stalled response must not move
        if (pending) begin
          check_value("res_way_o", res_way_o, held.way);
          check_value("res_hit_o", res_hit_o, held.hit);
          check_value("res_evict_o", res_evict_o, held.evict);
          check_value("res_evict_tag_o", res_evict_tag_o, held.tag);
        end
        if (res_ready_i) begin
          exp = exp_q.pop_front();
          check_value("res_way_o", res_way_o, exp.way);
          check_value("res_hit_o", res_hit_o, exp.hit);
          check_value("res_evict_o", res_evict_o, exp.evict);
          // Old tag only means something on a miss or a flush
          if (!exp.hit) begin
            check_value("res_evict_tag_o", res_evict_tag_o, exp.tag);
          end
          num_checked++;
          accepted = 1'b1;
          pending  = 1'b0;
        end else begin
          pending   = 1'b1;
          held.way  = res_way_o;
          held.hit  = res_hit_o;
          held.evict = res_evict_o;
          held.tag  = res_evict_tag_o;
        end
      end else if (pending) begin
        $display("res_valid_o dropped before the response was accepted");
        stop_on_failure();
      end
      if (accepted || exp_q.size() == 0) begin
        stall = 0;
      end else begin
        stall++;
        if (stall > RspTimeout) begin
          $display("no response arrived for an outstanding request");
          stop_on_failure();
        end
      end
    end
  endtask

  // Known sequence on one set, covers fill, upgrade, eviction, flush and lock
  task automatic run_directed();
    for (int unsigned t = 0; t < NumWays; t++) begin
      send_request(OpLookup, 6'd9, tag_t'(40 + t), 1'b0, '0, '0);
    end
    send_request(OpLookup, 6'd9, 10'd41, 1'b1, '0, '0);
    send_request(OpLookup, 6'd9, 10'd41, 1'b0, '0, '0);
    // Set full, pointer picks way 0 then the dirty way 1
    send_request(OpLookup, 6'd9, 10'd50, 1'b1, '0, '0);
    send_request(OpLookup, 6'd9, 10'd51, 1'b0, '0, '0);
    send_request(OpFlush, 6'd9, '0, 1'b0, 4'b0100, '0);
    send_request(OpFlush, 6'd9, '0, 1'b0, 4'b0001, '0);
    send_request(OpLookup, 6'd9, 10'd42, 1'b0, '0, '0);
    // Ways 0 and 2 locked
    for (int unsigned t = 0; t < NumWays; t++) begin
      send_request(OpLookup, 6'd9, tag_t'(50 + t), 1'b1, '0, 4'b0101);
    end
    send_request(OpLookup, 6'd9, 10'd60, 1'b0, '0, 4'b0101);
    send_request(OpLookup, 6'd9, 10'd61, 1'b0, '0, 4'b0101);
  endtask

  // Small index and tag ranges so hits and conflicts are frequent
  task automatic run_random(input int unsigned count);
    logic [31:0] r;
    op_e         op;
    way_t        way;
    way_t        lock;
    for (int unsigned n = 0; n < count; n++) begin
      r    = next_random(drv_state);
      op   = (r[31:29] == 3'd0) ? OpFlush : OpLookup;
      way  = way_t'(1) << r[22:21];
      lock = r[20] ? way_t'(r[19:16]) : '0;
      // At least one way stays open
      if (&lock) begin
        lock[r[15:14]] = 1'b0;
      end
      send_request(op, index_t'(r[28:27]), tag_t'(r[26:24]), r[23], way, lock);
      if (r[13:12] == 2'b00) begin
        idle_cycles(r[11:10]);
      end
    end
  endtask

  initial begin
    int unsigned waited;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    spm_lock_i   = '0;
    req_op_i     = OpLookup;
    req_index_i  = '0;
    req_tag_i    = '0;
    req_dirty_i  = 1'b0;
    req_way_i    = '0;
    req_valid_i  = 1'b0;
    res_ready_i  = 1'b0;
    stall_enable = 1'b0;
    drv_state    = Seed;
    rsp_state    = Seed ^ 32'h5a5a5a5a;
    num_sent     = 0;
    num_checked  = 0;
    reset_model();
    repeat (10) @(posedge clk_i);
    #DriveDelay;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("req_ready_o", req_ready_o, 1);
    check_value("res_valid_o", res_valid_o, 0);
    @(posedge clk_i);
    #DriveDelay;
    fork
      watch_responses();
    join_none
    run_directed();
    run_random(NumRandom / 4);
    stall_enable = 1'b1;
    run_random(NumRandom);
    stall_enable = 1'b0;
    // Let the last responses come out
    waited = 0;
    while (num_checked != num_sent && waited < DrainTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (num_checked == num_sent && exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("responses missing at the end, sent %0d, checked %0d", num_sent, num_checked);
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire
